/* hw/playgnd_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module playgnd_ctrl #(
  parameter int unsigned MstAddrWidth = 16,
  parameter int unsigned MstDataWidth = 32
) (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  // Register port
  input  logic                    reg_req_i,
  input  logic                    reg_we_i,
  input  playgnd_pkg::reg_addr_t  reg_addr_i,
  input  playgnd_pkg::reg_data_t  reg_wdata_i,
  output playgnd_pkg::reg_data_t  reg_rdata_o,
  // Timer side
  input  playgnd_pkg::mtime_t     mtime_i,
  input  logic                    irq_i,
  output logic                    timer_wr_o,
  output playgnd_pkg::mtime_t     timer_wdata_o,
  output playgnd_pkg::mtime_t     cmp_o,
  // Traffic generator side
  output logic                    tg_load_o,
  output logic                    tg_run_o,
  output logic [MstAddrWidth-1:0] tg_base_o,
  output playgnd_pkg::beat_cnt_t  tg_count_o,
  output logic [MstDataWidth-1:0] tg_pattern_o,
  input  logic                    tg_end_i
);

  typedef enum logic {
    StIdle,
    StRun
  } state_e;

  state_e state_q, state_d;

  logic                    wr_en;
  logic                    rd_en;
  logic                    start_req;
  logic                    busy;
  logic                    done_q;
  playgnd_pkg::mtime_t     cmp_q;
  logic [MstAddrWidth-1:0] base_q;
  playgnd_pkg::beat_cnt_t  count_q;
  logic [MstDataWidth-1:0] pattern_q;
  playgnd_pkg::reg_data_t  status;
  playgnd_pkg::reg_data_t  rdata_d;
  playgnd_pkg::reg_data_t  rdata_q;

  assign wr_en = reg_req_i & reg_we_i;
  assign rd_en = reg_req_i & ~reg_we_i;
  assign busy  = (state_q == StRun);

  // Start only from idle and with something to send
  assign start_req = wr_en && (reg_addr_i == playgnd_pkg::RegCtrl)
                     && reg_wdata_i[playgnd_pkg::CtrlStartBit]
                     && (state_q == StIdle) && (count_q != '0);

  ////////////////////////////////////////////////////////////////////////////
  // Register file
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cmp_q     <= '0;
      base_q    <= '0;
      count_q   <= '0;
      pattern_q <= '0;
    end else if (wr_en) begin
      case (reg_addr_i)
        playgnd_pkg::RegMtimecmp:  cmp_q     <= playgnd_pkg::mtime_t'(reg_wdata_i);
        playgnd_pkg::RegTgBase:    base_q    <= MstAddrWidth'(reg_wdata_i);
        playgnd_pkg::RegTgCount:   count_q   <= playgnd_pkg::beat_cnt_t'(reg_wdata_i);
        playgnd_pkg::RegTgPattern: pattern_q <= MstDataWidth'(reg_wdata_i);
        default: ;
      endcase
    end
  end

  // Timer load goes straight through since the timer owns mtime
  assign timer_wr_o    = wr_en && (reg_addr_i == playgnd_pkg::RegMtime);
  assign timer_wdata_o = playgnd_pkg::mtime_t'(reg_wdata_i);
  assign cmp_o         = cmp_q;

  ////////////////////////////////////////////////////////////////////////////
  // Burst FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      StIdle: if (start_req) state_d = StRun;
      StRun:  if (tg_end_i) state_d = StIdle;
      default: state_d = StIdle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= StIdle;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      // Sticky done is cleared by a new start
      if (start_req) begin
        done_q <= 1'b0;
      end else if (tg_end_i) begin
        done_q <= 1'b1;
      end
    end
  end

  assign tg_load_o    = start_req;
  assign tg_run_o     = busy;
  assign tg_base_o    = base_q;
  assign tg_count_o   = count_q;
  assign tg_pattern_o = pattern_q;

  ////////////////////////////////////////////////////////////////////////////
  // Read path
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    status = '0;
    status[playgnd_pkg::StatusBusyBit] = busy;
    status[playgnd_pkg::StatusDoneBit] = done_q;
    status[playgnd_pkg::StatusIrqBit]  = irq_i;
  end

  always_comb begin
    case (reg_addr_i)
      playgnd_pkg::RegMtime:     rdata_d = playgnd_pkg::reg_data_t'(mtime_i);
      playgnd_pkg::RegMtimecmp:  rdata_d = playgnd_pkg::reg_data_t'(cmp_q);
      playgnd_pkg::RegTgBase:    rdata_d = playgnd_pkg::reg_data_t'(base_q);
      playgnd_pkg::RegTgCount:   rdata_d = playgnd_pkg::reg_data_t'(count_q);
      playgnd_pkg::RegTgPattern: rdata_d = playgnd_pkg::reg_data_t'(pattern_q);
      playgnd_pkg::RegStatus:    rdata_d = status;
      default:                   rdata_d = '0;
    endcase
  end

  // Read data holds until the next read
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rdata_q <= '0;
    end else if (rd_en) begin
      rdata_q <= rdata_d;
    end
  end

  assign reg_rdata_o = rdata_q;

  // Busy and done never show together
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(busy && done_q));

  // Generator may only finish a burst this block started
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    tg_end_i |-> (state_q == StRun));

endmodule

`default_nettype wire

/* hw/playgnd_pkg.sv */
`default_nettype none

package playgnd_pkg;

  // Register port
  typedef logic [2:0]  reg_addr_t;
  typedef logic [31:0] reg_data_t;

  // Timer count and compare value
  typedef logic [31:0] mtime_t;

  // Burst length and beat index
  typedef logic [15:0] beat_cnt_t;

  ////////////////////////////////////////////////////////////////////////////
  // Register map in word indices
  ////////////////////////////////////////////////////////////////////////////

  localparam reg_addr_t RegMtime     = 3'd0;
  localparam reg_addr_t RegMtimecmp  = 3'd1;
  localparam reg_addr_t RegTgBase    = 3'd2;
  localparam reg_addr_t RegTgCount   = 3'd3;
  localparam reg_addr_t RegTgPattern = 3'd4;
  localparam reg_addr_t RegCtrl      = 3'd5;
  localparam reg_addr_t RegStatus    = 3'd6;

  // Control register bits
  localparam int unsigned CtrlStartBit = 0;

  // Status register bits
  localparam int unsigned StatusBusyBit = 0;
  localparam int unsigned StatusDoneBit = 1;
  localparam int unsigned StatusIrqBit  = 2;

endpackage

`default_nettype wire

/* hw/playgnd_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module playgnd_timer (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                rtc_i,
  input  logic                wr_i,
  input  playgnd_pkg::mtime_t wdata_i,
  input  playgnd_pkg::mtime_t cmp_i,
  output playgnd_pkg::mtime_t mtime_o,
  output logic                irq_o
);

  logic                rtc_sync_q1;
  logic                rtc_sync_q2;
  logic                rtc_prev_q;
  logic                rtc_rise;
  playgnd_pkg::mtime_t mtime_q;
  logic                irq_q;

  ////////////////////////////////////////////////////////////////////////////
  // RTC synchronizer and edge detect
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rtc_sync_q1 <= 1'b0;
      rtc_sync_q2 <= 1'b0;
      rtc_prev_q  <= 1'b0;
    end else begin
      rtc_sync_q1 <= rtc_i;
      rtc_sync_q2 <= rtc_sync_q1;
      rtc_prev_q  <= rtc_sync_q2;
    end
  end

  assign rtc_rise = rtc_sync_q2 & ~rtc_prev_q;

  ////////////////////////////////////////////////////////////////////////////
  // Counter and compare
  ////////////////////////////////////////////////////////////////////////////

  // Software write wins over a tick in the same cycle
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mtime_q <= '0;
    end else if (wr_i) begin
      mtime_q <= wdata_i;
    end else if (rtc_rise) begin
      mtime_q <= mtime_q + 1'b1;
    end
  end

  // Zero count against zero compare is already a hit
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      irq_q <= 1'b1;
    end else begin
      irq_q <= (mtime_q >= cmp_i);
    end
  end

  assign mtime_o = mtime_q;
  assign irq_o   = irq_q;

endmodule

`default_nettype wire

/* hw/playgnd_top.sv */
`timescale 1ns/1ps
`default_nettype none

module playgnd_top #(
  parameter int unsigned MstAddrWidth = 16,
  parameter int unsigned MstDataWidth = 32
) (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    rtc_i,
  // Register port
  input  logic                    reg_req_i,
  input  logic                    reg_we_i,
  input  playgnd_pkg::reg_addr_t  reg_addr_i,
  input  playgnd_pkg::reg_data_t  reg_wdata_i,
  output playgnd_pkg::reg_data_t  reg_rdata_o,
  // Master port
  input  logic                    mst_stall_i,
  output logic                    mst_we_o,
  output logic [MstAddrWidth-1:0] mst_addr_o,
  output logic [MstDataWidth-1:0] mst_wdata_o,
  // Timer interrupt
  output logic                    irq_o
);

  // Control to timer
  logic                    timer_wr;
  playgnd_pkg::mtime_t     timer_wdata;
  playgnd_pkg::mtime_t     cmp;
  playgnd_pkg::mtime_t     mtime;

  // Control to traffic generator
  logic                    tg_load;
  logic                    tg_run;
  logic [MstAddrWidth-1:0] tg_base;
  playgnd_pkg::beat_cnt_t  tg_count;
  logic [MstDataWidth-1:0] tg_pattern;
  logic                    tg_end;

  playgnd_ctrl #(
    .MstAddrWidth ( MstAddrWidth ),
    .MstDataWidth ( MstDataWidth )
  ) u_ctrl (
    .clk_i         ( clk_i       ),
    .rst_n_i       ( rst_n_i     ),
    .reg_req_i     ( reg_req_i   ),
    .reg_we_i      ( reg_we_i    ),
    .reg_addr_i    ( reg_addr_i  ),
    .reg_wdata_i   ( reg_wdata_i ),
    .reg_rdata_o   ( reg_rdata_o ),
    .mtime_i       ( mtime       ),
    .irq_i         ( irq_o       ),
    .timer_wr_o    ( timer_wr    ),
    .timer_wdata_o ( timer_wdata ),
    .cmp_o         ( cmp         ),
    .tg_load_o     ( tg_load     ),
    .tg_run_o      ( tg_run      ),
    .tg_base_o     ( tg_base     ),
    .tg_count_o    ( tg_count    ),
    .tg_pattern_o  ( tg_pattern  ),
    .tg_end_i      ( tg_end      )
  );

  playgnd_timer u_timer (
    .clk_i   ( clk_i       ),
    .rst_n_i ( rst_n_i     ),
    .rtc_i   ( rtc_i       ),
    .wr_i    ( timer_wr    ),
    .wdata_i ( timer_wdata ),
    .cmp_i   ( cmp         ),
    .mtime_o ( mtime       ),
    .irq_o   ( irq_o       )
  );

  playgnd_traffic_gen #(
    .MstAddrWidth ( MstAddrWidth ),
    .MstDataWidth ( MstDataWidth )
  ) u_traffic_gen (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .load_i      ( tg_load     ),
    .run_i       ( tg_run      ),
    .base_i      ( tg_base     ),
    .count_i     ( tg_count    ),
    .pattern_i   ( tg_pattern  ),
    .mst_stall_i ( mst_stall_i ),
    .mst_we_o    ( mst_we_o    ),
    .mst_addr_o  ( mst_addr_o  ),
    .mst_wdata_o ( mst_wdata_o ),
    .end_o       ( tg_end      )
  );

endmodule

`default_nettype wire

/* hw/playgnd_traffic_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module playgnd_traffic_gen #(
  parameter int unsigned MstAddrWidth = 16,
  parameter int unsigned MstDataWidth = 32
) (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  // Burst setup from control
  input  logic                    load_i,
  input  logic                    run_i,
  input  logic [MstAddrWidth-1:0] base_i,
  input  playgnd_pkg::beat_cnt_t  count_i,
  input  logic [MstDataWidth-1:0] pattern_i,
  // Master port
  input  logic                    mst_stall_i,
  output logic                    mst_we_o,
  output logic [MstAddrWidth-1:0] mst_addr_o,
  output logic [MstDataWidth-1:0] mst_wdata_o,
  output logic                    end_o
);

  playgnd_pkg::beat_cnt_t  idx_q;
  playgnd_pkg::beat_cnt_t  last_idx;
  logic                    beat_ok;
  logic [MstAddrWidth-1:0] idx_addr;
  logic [MstDataWidth-1:0] idx_data;

  // Accepted beat
  assign beat_ok  = run_i & ~mst_stall_i;
  assign last_idx = count_i - 1'b1;

  ////////////////////////////////////////////////////////////////////////////
  // Beat index
  ////////////////////////////////////////////////////////////////////////////

  // Index holds while stalled
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      idx_q <= '0;
    end else if (load_i) begin
      idx_q <= '0;
    end else if (beat_ok) begin
      idx_q <= idx_q + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Beat payload
  ////////////////////////////////////////////////////////////////////////////

  assign idx_addr = MstAddrWidth'(idx_q);
  assign idx_data = MstDataWidth'(idx_q);

  // Address wraps at the port width
  assign mst_we_o    = run_i;
  assign mst_addr_o  = base_i + idx_addr;
  assign mst_wdata_o = pattern_i ^ idx_data;

  assign end_o = beat_ok && (idx_q == last_idx);

  // A stalled beat is presented again unchanged
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (mst_we_o && mst_stall_i) |=>
      (mst_we_o && $stable(mst_addr_o) && $stable(mst_wdata_o)));

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_playgnd \
  -f vlog.f \
  --Mdir obj_dir -o tb_playgnd

./obj_dir/tb_playgnd | tee sim.log

if grep -q "Simulation failed" sim.log; then
  echo "Run FAILED, see sim.log"
  exit 1
fi
echo "Run passed"

/* testbench/tb_playgnd.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_playgnd;

  localparam int unsigned AddrW = 16;
  localparam int unsigned DataW = 32;

  typedef enum logic [2:0] {OpWrite, OpRead, OpBurst, OpRtc, OpIrq} op_e;

  typedef struct packed {
    op_e                    op;
    playgnd_pkg::reg_addr_t addr;
    playgnd_pkg::reg_data_t data;
    logic [AddrW-1:0]       base;
    playgnd_pkg::beat_cnt_t count;
    logic [DataW-1:0]       pattern;
    logic                   stall;
    logic                   restart;
    logic                   done;
  } op_t;

  logic                   clk_i;
  logic                   rst_n_i;
  logic                   rtc_i;
  logic                   reg_req_i;
  logic                   reg_we_i;
  playgnd_pkg::reg_addr_t reg_addr_i;
  playgnd_pkg::reg_data_t reg_wdata_i;
  playgnd_pkg::reg_data_t reg_rdata_o;
  logic                   mst_stall_i;
  logic                   mst_we_o;
  logic [AddrW-1:0]       mst_addr_o;
  logic [DataW-1:0]       mst_wdata_o;
  logic                   irq_o;

  op_t              ops[$];
  string            names[$];
  logic [AddrW-1:0] addr_q[$];
  logic [DataW-1:0] data_q[$];
  int               errors = 0;
  int               cycles = 0;
  int               limit = 0;
  logic             stall_en = 1'b0;
  logic [31:0]      lfsr = 32'd73426;
  logic             hold_pending = 1'b0;
  logic [AddrW-1:0] held_addr;
  logic [DataW-1:0] held_data;

  playgnd_top #(
    .MstAddrWidth ( AddrW ),
    .MstDataWidth ( DataW )
  ) u_dut (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .rtc_i       ( rtc_i       ),
    .reg_req_i   ( reg_req_i   ),
    .reg_we_i    ( reg_we_i    ),
    .reg_addr_i  ( reg_addr_i  ),
    .reg_wdata_i ( reg_wdata_i ),
    .reg_rdata_o ( reg_rdata_o ),
    .mst_stall_i ( mst_stall_i ),
    .mst_we_o    ( mst_we_o    ),
    .mst_addr_o  ( mst_addr_o  ),
    .mst_wdata_o ( mst_wdata_o ),
    .irq_o       ( irq_o       )
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_data(input string name, input playgnd_pkg::reg_data_t exp,
                            input playgnd_pkg::reg_data_t act);
    if (exp !== act) begin
      $display("Error %s expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_beat(input string name, input logic [AddrW-1:0] exp_addr,
                            input logic [DataW-1:0] exp_data, input logic [AddrW-1:0] act_addr,
                            input logic [DataW-1:0] act_data);
    if (exp_addr !== act_addr || exp_data !== act_data) begin
      $display("Error %s expected %h/%h actual %h/%h", name, exp_addr, exp_data,
               act_addr, act_data);
      errors++;
    end
  endtask

  task automatic check_level(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("Error %s expected %b actual %b", name, exp, act);
      errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stall source and beat monitor
  ////////////////////////////////////////////////////////////////////////////

  // Galois LFSR stepped once per stall bit
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    lfsr_step = s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
  endfunction

  always @(posedge clk_i) begin
    if (stall_en) begin
      lfsr = lfsr_step(lfsr);
      mst_stall_i <= lfsr[0];
    end else begin
      mst_stall_i <= 1'b0;
    end
  end

  // Sampled mid-cycle since acceptance happens at the next rising edge
  always @(negedge clk_i) begin
    if (rst_n_i) begin
      if (hold_pending) begin
        check_level("stall_hold we", 1'b1, mst_we_o);
        check_beat("stall_hold", held_addr, held_data, mst_addr_o, mst_wdata_o);
      end
      hold_pending = mst_we_o && mst_stall_i;
      held_addr    = mst_addr_o;
      held_data    = mst_wdata_o;
      if (mst_we_o && !mst_stall_i) begin
        addr_q.push_back(mst_addr_o);
        data_q.push_back(mst_wdata_o);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Register port and stimulus tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic reg_write(input playgnd_pkg::reg_addr_t addr,
                           input playgnd_pkg::reg_data_t data);
    @(posedge clk_i);
    reg_req_i   <= 1'b1;
    reg_we_i    <= 1'b1;
    reg_addr_i  <= addr;
    reg_wdata_i <= data;
    @(posedge clk_i);
    reg_req_i <= 1'b0;
    reg_we_i  <= 1'b0;
  endtask

  task automatic reg_read(input playgnd_pkg::reg_addr_t addr,
                          output playgnd_pkg::reg_data_t data);
    @(posedge clk_i);
    reg_req_i  <= 1'b1;
    reg_we_i   <= 1'b0;
    reg_addr_i <= addr;
    @(posedge clk_i);
    reg_req_i <= 1'b0;
    @(negedge clk_i);
    data = reg_rdata_o;
  endtask

  task automatic run_burst(input string name, input op_t o);
    playgnd_pkg::reg_data_t status;
    logic [AddrW-1:0]       exp_addr;
    logic [DataW-1:0]       exp_data;
    @(negedge clk_i);
    stall_en = o.stall;
    addr_q.delete();
    data_q.delete();
    reg_write(playgnd_pkg::RegTgBase, playgnd_pkg::reg_data_t'(o.base));
    reg_write(playgnd_pkg::RegTgCount, playgnd_pkg::reg_data_t'(o.count));
    reg_write(playgnd_pkg::RegTgPattern, o.pattern);
    reg_write(playgnd_pkg::RegCtrl, 32'h1);
    // Second start lands while the first burst still runs
    if (o.restart) begin
      reg_write(playgnd_pkg::RegCtrl, 32'h1);
    end
    @(negedge clk_i);
    while (mst_we_o) begin
      @(negedge clk_i);
    end
    stall_en = 1'b0;
    check_data({name, " beats"}, playgnd_pkg::reg_data_t'(o.count),
               playgnd_pkg::reg_data_t'(addr_q.size()));
    for (int i = 0; i < int'(o.count) && i < addr_q.size(); i++) begin
      exp_addr = o.base + AddrW'(i);
      exp_data = o.pattern ^ DataW'(i);
      check_beat($sformatf("%s beat %0d", name, i), exp_addr, exp_data, addr_q[i], data_q[i]);
    end
    reg_read(playgnd_pkg::RegStatus, status);
    check_level({name, " busy"}, 1'b0, status[playgnd_pkg::StatusBusyBit]);
    check_level({name, " done"}, o.done, status[playgnd_pkg::StatusDoneBit]);
  endtask

  // Four clk_i cycles per half period of the slow clock
  task automatic toggle_rtc(input int k);
    repeat (k) begin
      @(posedge clk_i);
      rtc_i <= 1'b1;
      repeat (3) @(posedge clk_i);
      @(posedge clk_i);
      rtc_i <= 1'b0;
      repeat (3) @(posedge clk_i);
    end
    repeat (4) @(posedge clk_i);
  endtask

  task automatic check_irq(input string name, input logic exp);
    playgnd_pkg::reg_data_t status;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    check_level({name, " irq_o"}, exp, irq_o);
    reg_read(playgnd_pkg::RegStatus, status);
    check_level({name, " status"}, exp, status[playgnd_pkg::StatusIrqBit]);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Operation table
  ////////////////////////////////////////////////////////////////////////////

  task automatic add_op(input string name, input op_e op, input playgnd_pkg::reg_addr_t addr,
                        input playgnd_pkg::reg_data_t data);
    op_t o;
    o = '0;
    o.op   = op;
    o.addr = addr;
    o.data = data;
    ops.push_back(o);
    names.push_back(name);
  endtask

  task automatic add_burst(input string name, input logic [AddrW-1:0] base,
                           input playgnd_pkg::beat_cnt_t count, input logic [DataW-1:0] pattern,
                           input logic stall, input logic restart, input logic done);
    op_t o;
    o = '0;
    o.op      = OpBurst;
    o.base    = base;
    o.count   = count;
    o.pattern = pattern;
    o.stall   = stall;
    o.restart = restart;
    o.done    = done;
    ops.push_back(o);
    names.push_back(name);
  endtask

  task automatic build_table();
    add_op("irq_after_reset", OpIrq, '0, 32'h1);
    add_op("wr_cmp", OpWrite, playgnd_pkg::RegMtimecmp, 32'hDEAD_BEEF);
    add_op("rd_cmp", OpRead, playgnd_pkg::RegMtimecmp, 32'hDEAD_BEEF);
    add_op("wr_base", OpWrite, playgnd_pkg::RegTgBase, 32'h0000_1FF0);
    add_op("rd_base", OpRead, playgnd_pkg::RegTgBase, 32'h0000_1FF0);
    add_op("wr_count", OpWrite, playgnd_pkg::RegTgCount, 32'h0000_0005);
    add_op("rd_count", OpRead, playgnd_pkg::RegTgCount, 32'h0000_0005);
    add_op("wr_pattern", OpWrite, playgnd_pkg::RegTgPattern, 32'hA5A5_0F0F);
    add_op("rd_pattern", OpRead, playgnd_pkg::RegTgPattern, 32'hA5A5_0F0F);
    add_op("rd_unused", OpRead, 3'd7, 32'h0);
    // Base near the top so the address wraps
    add_burst("burst_plain", 16'hFFFC, 16'd8, 32'h1234_5678, 1'b0, 1'b0, 1'b1);
    add_burst("burst_stall", 16'h0100, 16'd20, 32'hCAFE_0000, 1'b1, 1'b0, 1'b1);
    add_burst("start_zero", 16'h0200, 16'd0, 32'h0000_0000, 1'b0, 1'b0, 1'b1);
    add_burst("start_busy", 16'h0300, 16'd6, 32'h0F0F_F0F0, 1'b0, 1'b1, 1'b1);
    add_op("wr_mtime", OpWrite, playgnd_pkg::RegMtime, 32'h0000_0100);
    add_op("rtc_edges", OpRtc, '0, 32'd5);
    add_op("rd_mtime", OpRead, playgnd_pkg::RegMtime, 32'h0000_0105);
    add_op("wr_cmp_low", OpWrite, playgnd_pkg::RegMtimecmp, 32'h0000_0100);
    add_op("irq_high", OpIrq, '0, 32'h1);
    add_op("wr_cmp_high", OpWrite, playgnd_pkg::RegMtimecmp, 32'h0000_1000);
    add_op("irq_low", OpIrq, '0, 32'h0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence and timeout
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    playgnd_pkg::reg_data_t rdata;
    int                     budget;
    rst_n_i     = 1'b0;
    rtc_i       = 1'b0;
    reg_req_i   = 1'b0;
    reg_we_i    = 1'b0;
    reg_addr_i  = '0;
    reg_wdata_i = '0;
    mst_stall_i = 1'b0;
    build_table();
    budget = 8;
    foreach (ops[i]) begin
      budget += 20;
      if (ops[i].op == OpBurst) begin
        budget += 4 * int'(ops[i].count) + 30;
      end else if (ops[i].op == OpRtc) begin
        budget += 8 * int'(ops[i].data) + 10;
      end
    end
    limit = 2 * budget;
    repeat (8) @(posedge clk_i);
    rst_n_i <= 1'b1;
    foreach (ops[i]) begin
      case (ops[i].op)
        OpWrite: reg_write(ops[i].addr, ops[i].data);
        OpRead: begin
          reg_read(ops[i].addr, rdata);
          check_data(names[i], ops[i].data, rdata);
        end
        OpBurst: run_burst(names[i], ops[i]);
        OpRtc:   toggle_rtc(int'(ops[i].data));
        default: check_irq(names[i], ops[i].data[0]);
      endcase
    end
    repeat (4) @(posedge clk_i);
    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    wait (limit != 0);
    while (cycles < limit) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d clock cycles", limit);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
hw/playgnd_pkg.sv
hw/playgnd_ctrl.sv
hw/playgnd_timer.sv
hw/playgnd_traffic_gen.sv
hw/playgnd_top.sv
testbench/tb_playgnd.sv
